// File: list.f
+incdir+.
vector_pkg.sv
vaddsub.sv
vector_wb_regs.sv
vector_seq.sv
vector_unit_top.sv
tb_vector_unit.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_vector_unit -Mdir "$BUILD" -o sim -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// File: tb_fp16_model.svh
`ifndef TB_FP16_MODEL_SVH
`define TB_FP16_MODEL_SVH

function automatic logic has_nan_code(input logic [15:0] f);
    return (f[14:10] == 5'h1F) && (f[9:0] != 10'd0);
endfunction

function automatic logic is_infinite(input logic [15:0] f);
    return (f[14:10] == 5'h1F) && (f[9:0] == 10'd0);
endfunction

// Finite fp16 as a signed integer in units of 2**-24
function automatic longint scale_exact(input logic [15:0] f);
    longint mag;
    if (f[14:10] == 5'd0) begin
        mag = longint'(f[9:0]);                                   // Subnormal, frac is exact
    end else begin
        mag = longint'({1'b1, f[9:0]}) << (f[14:10] - 5'd1);
    end
    return f[15] ? -mag : mag;
endfunction

// Round to nearest even; bit 16 of the result flags overflow
function automatic logic [16:0] round_to_half(input longint val);
    logic        sign;
    logic [63:0] mag;
    logic [63:0] sig;
    logic [63:0] rem;
    logic [63:0] half;
    int          msb;
    int          shift;
    int          e;
    sign = (val < 0);
    mag  = sign ? -val : val;
    if (mag == 64'd0) begin
        return 17'h0_0000;                                        // Zero sum is +0
    end
    if (mag < 64'd2048) begin
        // Subnormal or lowest binade needs no rounding
        return {1'b0, sign, (mag >= 64'd1024) ? 5'd1 : 5'd0, mag[9:0]};
    end
    msb = 0;
    for (int i = 0; i < 64; i++) begin
        if (mag[i]) begin
            msb = i;
        end
    end
    shift = msb - 10;
    e     = msb - 9;
    sig   = mag >> shift;
    rem   = mag & ((64'd1 << shift) - 64'd1);
    half  = 64'd1 << (shift - 1);
    if ((rem > half) || ((rem == half) && sig[0])) begin
        sig = sig + 64'd1;
    end
    if (sig == 64'd2048) begin
        sig = 64'd1024;                                           // Carry into next binade
        e   = e + 1;
    end
    if (e >= 31) begin
        return {1'b1, sign, 5'h1F, 10'h000};
    end
    return {1'b0, sign, 5'(e), sig[9:0]};
endfunction

// Expected {overflow, result} of a + b or a - b
function automatic logic [16:0] expected_sum(input logic [15:0] a, input logic [15:0] b,
                                             input logic sub);
    logic [15:0] bx;
    bx = {b[15] ^ sub, b[14:0]};
    if (has_nan_code(a) || has_nan_code(bx)) begin
        return {1'b0, 16'h7E00};
    end
    if (is_infinite(a) && is_infinite(bx)) begin
        return (a[15] == bx[15]) ? {1'b0, a} : {1'b0, 16'h7E00};
    end
    if (is_infinite(a)) begin
        return {1'b0, a};
    end
    if (is_infinite(bx)) begin
        return {1'b0, bx};
    end
    return round_to_half(scale_exact(a) + scale_exact(bx));
endfunction

`endif

// File: tb_vector_unit.sv
`include "vector_defs.svh"

module tb_vector_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_OPS   = 200;
    localparam int OP_CYCLES = 100;                  // Nine writes, status polls, four reads, margin
    localparam int TIMEOUT   = MAX_OPS * OP_CYCLES;
    localparam logic [15:0] POS_INF = 16'h7C00;
    localparam logic [15:0] NEG_INF = 16'hFC00;

    logic                  CLK;
    logic                  nRST;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADDR_W-1:0] wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;
    int                    cycles;
    logic [15:0]           a_op [`VEC_LANES];
    logic [15:0]           b_op [`VEC_LANES];

    `include "tb_fp16_model.svh"

    vector_unit_top vector_unit_top_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
            $display("Test failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch");
        end
    endtask

    task automatic wb_write(input logic [`WB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge CLK);
        compare_value("wb_ack idle", {31'h0, wb_ack}, 32'h0);   // Ack lasts one cycle
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        do begin
            @(posedge CLK);
        end while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`WB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge CLK);
        compare_value("wb_ack idle", {31'h0, wb_ack}, 32'h0);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        do begin
            @(posedge CLK);
        end while (!wb_ack);
        data   = wb_dat_r;                           // Registered with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    // Kind 0 normal, 1 subnormal, 2 lowest binades, 3 NaN
    function automatic logic [15:0] gen_operand(input int kind);
        case (kind)
            1:       return {1'($urandom), 5'd0, 10'($urandom)};
            2:       return {1'($urandom), 5'($urandom_range(2, 1)), 10'($urandom)};
            3:       return {1'($urandom), 5'h1F, 10'($urandom_range(1023, 1))};
            default: return {1'($urandom), 5'($urandom_range(30, 1)), 10'($urandom)};
        endcase
    endfunction

    task automatic run_vector_op(input logic sub);
        logic [31:0]           status;
        logic [31:0]           rdata;
        logic [16:0]           model;
        logic [`VEC_LANES-1:0] ovf_exp;
        ovf_exp = '0;
        for (int i = 0; i < `VEC_LANES; i++) begin
            wb_write(`WB_ADDR_W'(`REG_A_BASE + 4 * i), {16'h0, a_op[i]});
            wb_write(`WB_ADDR_W'(`REG_B_BASE + 4 * i), {16'h0, b_op[i]});
        end
        wb_write(`REG_CTRL, {30'h0, sub, 1'b1});
        do begin
            wb_read(`REG_STATUS, status);
            if (status[0]) begin
                // Start has cleared done and the overflow flags
                compare_value("STATUS.done", {31'h0, status[1]}, 32'h0);
                compare_value("STATUS.ovf", {28'h0, status[11:8]}, 32'h0);
            end
        end while (!status[1]);
        for (int i = 0; i < `VEC_LANES; i++) begin
            model      = expected_sum(a_op[i], b_op[i], sub);
            ovf_exp[i] = model[16];
            wb_read(`WB_ADDR_W'(`REG_R_BASE + 4 * i), rdata);
            compare_value($sformatf("R[%0d]", i), rdata, {16'h0, model[15:0]});
        end
        compare_value("STATUS", status, {20'h0, ovf_exp, 8'h02});
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata [2 * `VEC_LANES];
        CLK      = 1'b0;
        nRST     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        cycles   = 0;
        void'($urandom(32'h1502_6534));
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        wb_read(`REG_STATUS, rdata);
        compare_value("STATUS after reset", rdata, 32'h0);
        for (int i = 0; i < 2 * `VEC_LANES; i++) begin   // A then B registers
            wdata[i] = $urandom;
            wb_write(`WB_ADDR_W'(`REG_A_BASE + 4 * i), wdata[i]);
        end
        for (int i = 0; i < 2 * `VEC_LANES; i++) begin
            wb_read(`WB_ADDR_W'(`REG_A_BASE + 4 * i), rdata);
            compare_value($sformatf("operand %0d", i), rdata, {16'h0, wdata[i][15:0]});
        end

        for (int k = 0; k < 40; k++) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                a_op[i] = gen_operand(0);
                b_op[i] = gen_operand(0);
            end
            run_vector_op(1'b0);
        end

        for (int k = 0; k < 40; k++) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                a_op[i] = gen_operand(0);
                b_op[i] = (i == k % `VEC_LANES) ? a_op[i] : gen_operand(0);   // One cancels
            end
            run_vector_op(1'b1);
        end

        // NaN, infinity and mixed operands
        a_op = '{gen_operand(3), gen_operand(0), POS_INF, NEG_INF};
        b_op = '{gen_operand(0), gen_operand(3), gen_operand(0), gen_operand(0)};
        run_vector_op(1'b0);
        a_op = '{POS_INF, NEG_INF, gen_operand(0), POS_INF};
        b_op = '{POS_INF, NEG_INF, POS_INF, gen_operand(0)};
        run_vector_op(1'b1);
        a_op = '{POS_INF, POS_INF, gen_operand(3), gen_operand(0)};
        b_op = '{NEG_INF, POS_INF, POS_INF, NEG_INF};
        run_vector_op(1'b0);

        // Effective signs equal near the top of the range
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                a_op[i] = {1'(i), 5'd30, 10'h380 | 10'($urandom)};
                b_op[i] = {1'(i) ^ 1'(k), 5'd30, 10'h380 | 10'($urandom)};
            end
            run_vector_op(1'(k));
        end

        for (int k = 0; k < 30; k++) begin
            for (int i = 0; i < `VEC_LANES; i++) begin
                a_op[i] = gen_operand(1);
                b_op[i] = gen_operand(int'($urandom_range(2, 1)));
            end
            run_vector_op(1'($urandom));
        end

        $display("Test passed");
        $finish;
    end

endmodule

// File: vaddsub.sv
module vaddsub (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              enable,
    input  logic              sub,
    input  vector_pkg::fp16_t port_a,
    input  vector_pkg::fp16_t port_b,
    output vector_pkg::fp16_t res,
    output logic              ovf,
    output logic              res_valid
);

    localparam int EXP_W  = 5;
    localparam int FRAC_W = 10;
    localparam int SIG_W  = FRAC_W + 1;   // With hidden bit
    localparam int GRS_W  = 3;
    localparam int EXT_W  = SIG_W + GRS_W;
    localparam int SUM_W  = EXT_W + 1;    // Room for the add carry
    localparam logic [15:0] QNAN = 16'h7E00;

    function automatic logic is_nan(input vector_pkg::fp16_t f);
        return (f.exp == 5'h1F) && (f.frac != '0);
    endfunction

    function automatic logic is_inf(input vector_pkg::fp16_t f);
        return (f.exp == 5'h1F) && (f.frac == '0);
    endfunction

    // Subnormals align as exponent 1
    function automatic logic [EXP_W-1:0] eff_exp(input vector_pkg::fp16_t f);
        return (f.exp == '0) ? EXP_W'(1) : f.exp;
    endfunction

    // Hidden bit only for normals
    function automatic logic [SIG_W-1:0] make_sig(input vector_pkg::fp16_t f);
        return {(f.exp != '0), f.frac};
    endfunction

    // Right shift, shifted-out bits ORed into bit 0
    function automatic logic [EXT_W-1:0] align_sticky(input logic [EXT_W-1:0] x,
                                                      input logic [EXP_W-1:0] shamt);
        logic [EXT_W-1:0] y;
        logic [EXT_W-1:0] mask;
        if (shamt >= EXP_W'(EXT_W)) begin
            y    = '0;
            y[0] = |x;
        end else begin
            mask = (EXT_W'(1) << shamt) - EXT_W'(1);
            y    = x >> shamt;
            y[0] = y[0] | (|(x & mask));
        end
        return y;
    endfunction

    function automatic logic [3:0] lzc(input logic [SUM_W-1:0] x);
        logic [3:0] cnt;
        cnt = 4'(SUM_W);
        for (int i = 0; i < SUM_W; i++) begin
            if (x[i]) begin
                cnt = 4'(SUM_W - 1 - i);   // Highest set bit wins
            end
        end
        return cnt;
    endfunction

    // Stage 1 signals
    logic               sign_a;
    logic               sign_b;
    logic [SIG_W-1:0]   sig_a;
    logic [SIG_W-1:0]   sig_b;
    logic [EXP_W-1:0]   exp_a;
    logic [EXP_W-1:0]   exp_b;
    logic               swap;
    logic [EXP_W-1:0]   ediff;
    logic               s1n_special;
    vector_pkg::fp16_t  s1n_special_res;

    logic               s1_v;
    logic               s1_special;
    vector_pkg::fp16_t  s1_special_res;
    logic [EXT_W-1:0]   s1_big;
    logic [EXT_W-1:0]   s1_small;
    logic [EXP_W-1:0]   s1_exp;
    logic               s1_sign;
    logic               s1_add;

    // Stage 2 signals
    logic [SUM_W-1:0]   s2n_mag;
    logic               s2_v;
    logic [SUM_W-1:0]   s2_mag;
    logic [EXP_W-1:0]   s2_exp;
    logic               s2_sign;
    logic               s2_special;
    vector_pkg::fp16_t  s2_special_res;

    // Stage 3 signals
    logic [3:0]         lz;
    logic [3:0]         shl;
    logic [SUM_W-1:0]   norm;
    logic [5:0]         exp_n;
    logic [SIG_W-1:0]   sig_t;
    logic               inc;
    logic [SIG_W:0]     sig_rnd;
    logic [5:0]         exp_post;
    vector_pkg::fp16_t  s3n_res;
    logic               s3n_ovf;
    logic               s3_v;
    vector_pkg::fp16_t  s3_res;
    logic               s3_ovf;

    assign sign_a = port_a.sign;
    assign sign_b = port_b.sign ^ sub;   // Subtract flips b
    assign sig_a  = make_sig(port_a);
    assign sig_b  = make_sig(port_b);
    assign exp_a  = eff_exp(port_a);
    assign exp_b  = eff_exp(port_b);
    assign swap   = (exp_b > exp_a) || ((exp_b == exp_a) && (sig_b > sig_a));
    assign ediff  = swap ? (exp_b - exp_a) : (exp_a - exp_b);

    // NaN and infinity classification
    always_comb begin
        s1n_special     = 1'b1;
        s1n_special_res = QNAN;
        if (is_nan(port_a) || is_nan(port_b)) begin
            s1n_special_res = QNAN;
        end else if (is_inf(port_a) && is_inf(port_b)) begin
            // Opposite infinities cancel into NaN
            s1n_special_res = (sign_a != sign_b) ? QNAN : {sign_a, 5'h1F, 10'h000};
        end else if (is_inf(port_a)) begin
            s1n_special_res = {sign_a, 5'h1F, 10'h000};
        end else if (is_inf(port_b)) begin
            s1n_special_res = {sign_b, 5'h1F, 10'h000};
        end else begin
            s1n_special = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            s1_v <= 1'b0;
            s2_v <= 1'b0;
            s3_v <= 1'b0;
        end else begin
            s1_v <= enable;
            s2_v <= s1_v;
            s3_v <= s2_v;
        end
    end

    // Stage 1 order by magnitude and align the smaller one
    always_ff @(posedge CLK) begin
        if (enable) begin
            s1_special     <= s1n_special;
            s1_special_res <= s1n_special_res;
            s1_big         <= swap ? {sig_b, {GRS_W{1'b0}}} : {sig_a, {GRS_W{1'b0}}};
            s1_small       <= align_sticky(swap ? {sig_a, {GRS_W{1'b0}}}
                                                : {sig_b, {GRS_W{1'b0}}}, ediff);
            s1_exp         <= swap ? exp_b : exp_a;
            s1_sign        <= swap ? sign_b : sign_a;   // Larger magnitude sets the sign
            s1_add         <= (sign_a == sign_b);
        end
    end

    // Stage 2 magnitude add or subtract, big >= small
    assign s2n_mag = s1_add ? ({1'b0, s1_big} + {1'b0, s1_small})
                            : ({1'b0, s1_big} - {1'b0, s1_small});

    always_ff @(posedge CLK) begin
        if (s1_v) begin
            s2_mag         <= s2n_mag;
            s2_exp         <= s1_exp;
            s2_sign        <= s1_sign;
            s2_special     <= s1_special;
            s2_special_res <= s1_special_res;
        end
    end

    // Stage 3 normalize, round and pack
    always_comb begin
        lz    = lzc(s2_mag);
        shl   = lz - 4'd1;        // Leading one belongs at bit EXT_W-1
        norm  = s2_mag;
        exp_n = 6'(s2_exp);
        if (s2_mag[SUM_W-1]) begin
            norm    = s2_mag >> 1;
            norm[0] = s2_mag[1] | s2_mag[0];
            exp_n   = 6'(s2_exp) + 6'd1;
        end else if ({1'b0, shl} < s2_exp) begin
            norm  = s2_mag << shl;
            exp_n = 6'(s2_exp) - 6'(shl);
        end else begin
            // Exponent runs out first, result is subnormal
            norm  = s2_mag << (s2_exp - 5'd1);
            exp_n = '0;
        end

        sig_t   = norm[GRS_W +: SIG_W];
        inc     = norm[2] & (norm[1] | norm[0] | sig_t[0]);   // Ties to even
        sig_rnd = {1'b0, sig_t} + {{SIG_W{1'b0}}, inc};

        if (exp_n == '0) begin
            exp_post = {5'b0, sig_rnd[FRAC_W]};   // May round up to the smallest normal
        end else begin
            exp_post = exp_n + {5'b0, sig_rnd[SIG_W]};
        end

        s3n_ovf = 1'b0;
        if (s2_special) begin
            s3n_res = s2_special_res;
        end else if (s2_mag == '0) begin
            s3n_res = '0;                           // Exact cancellation is +0
        end else if (exp_post >= 6'd31) begin
            s3n_res = {s2_sign, 5'h1F, 10'h000};
            s3n_ovf = 1'b1;
        end else begin
            s3n_res = {s2_sign, exp_post[4:0], sig_rnd[FRAC_W-1:0]};
        end
    end

    always_ff @(posedge CLK) begin
        if (s2_v) begin
            s3_res <= s3n_res;
            s3_ovf <= s3n_ovf;
        end
    end

    assign res       = s3_v ? s3_res : '0;
    assign ovf       = s3_v ? s3_ovf : 1'b0;
    assign res_valid = s3_v;

    // Fixed three-cycle latency
    a_latency: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid == $past(enable, 3));

endmodule

// File: vector_defs.svh
`ifndef VECTOR_DEFS_SVH
`define VECTOR_DEFS_SVH

// Number of parallel fp16 lanes
`define VEC_LANES   4

// Wishbone classic widths
`define WB_ADDR_W   8       // Byte address
`define WB_DATA_W   32

// Register map
`define REG_CTRL    8'h00   // Bit 0 start, bit 1 subtract
`define REG_STATUS  8'h04   // Bit 0 busy, bit 1 done, bits 8+ overflow per lane

// Lane i sits at base + 4*i, value in bits 15:0
`define REG_A_BASE  8'h10
`define REG_B_BASE  8'h20
`define REG_R_BASE  8'h30

`endif

// File: vector_pkg.sv
package vector_pkg;

    // IEEE half precision
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;   // Biased by 15
        logic [9:0] frac;
    } fp16_t;

    // Operation selected by CTRL bit 1
    typedef enum logic {
        VOP_ADD = 1'b0,
        VOP_SUB = 1'b1
    } vec_op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ISSUE = 2'd1,  // Enable pulse to the lanes
        SEQ_WAIT  = 2'd2   // Waiting on res_valid
    } seq_state_t;

endpackage

// File: vector_seq.sv
module vector_seq (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                start,
    input  vector_pkg::vec_op_t op,
    input  logic                res_valid,
    output logic                enable,
    output logic                sub,
    output logic                capture,
    output logic                busy
);

    vector_pkg::seq_state_t state;
    vector_pkg::seq_state_t state_next;
    vector_pkg::vec_op_t    op_q;   // Held for the whole operation

    always_comb begin
        state_next = state;
        case (state)
            vector_pkg::SEQ_IDLE: begin
                if (start) begin
                    state_next = vector_pkg::SEQ_ISSUE;
                end
            end
            vector_pkg::SEQ_ISSUE: begin
                state_next = vector_pkg::SEQ_WAIT;
            end
            vector_pkg::SEQ_WAIT: begin
                if (res_valid) begin
                    state_next = vector_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_next = vector_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state  <= vector_pkg::SEQ_IDLE;
            op_q   <= vector_pkg::VOP_ADD;
            enable <= 1'b0;
        end else begin
            state  <= state_next;
            enable <= (state_next == vector_pkg::SEQ_ISSUE);   // Registered issue pulse
            if ((state == vector_pkg::SEQ_IDLE) && start) begin
                op_q <= op;
            end
        end
    end

    assign sub     = (op_q == vector_pkg::VOP_SUB);
    assign capture = (state == vector_pkg::SEQ_WAIT) && res_valid;
    assign busy    = (state != vector_pkg::SEQ_IDLE);

    // No stray lane result outside an operation
    a_valid_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
        res_valid |-> (state == vector_pkg::SEQ_WAIT));

    // Lane result must come from the issued enable
    a_capture_latency: assert property (@(posedge CLK) disable iff (!nRST)
        capture |-> $past(enable, 3));

endmodule

// File: vector_unit_top.sv
`include "vector_defs.svh"

module vector_unit_top (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADDR_W-1:0] wb_adr,
    input  logic [`WB_DATA_W-1:0] wb_dat_w,
    output logic [`WB_DATA_W-1:0] wb_dat_r,
    output logic                  wb_ack
);

    logic                               start;
    vector_pkg::vec_op_t                op;
    logic                               enable;
    logic                               sub;
    logic                               capture;
    logic                               busy;
    vector_pkg::fp16_t [`VEC_LANES-1:0] a_vec;
    vector_pkg::fp16_t [`VEC_LANES-1:0] b_vec;
    vector_pkg::fp16_t [`VEC_LANES-1:0] res;
    logic [`VEC_LANES-1:0]              ovf;
    logic [`VEC_LANES-1:0]              lane_valid;

    vector_wb_regs regs_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .capture  (capture),
        .busy     (busy),
        .res      (res),
        .ovf      (ovf),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .start    (start),
        .op       (op),
        .a_vec    (a_vec),
        .b_vec    (b_vec)
    );

    // Lanes run in lockstep so lane 0 stands for all
    vector_seq seq_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .start     (start),
        .op        (op),
        .res_valid (lane_valid[0]),
        .enable    (enable),
        .sub       (sub),
        .capture   (capture),
        .busy      (busy)
    );

    for (genvar i = 0; i < `VEC_LANES; i++) begin : g_lane
        vaddsub lane_i (
            .CLK       (CLK),
            .nRST      (nRST),
            .enable    (enable),
            .sub       (sub),
            .port_a    (a_vec[i]),
            .port_b    (b_vec[i]),
            .res       (res[i]),
            .ovf       (ovf[i]),
            .res_valid (lane_valid[i])
        );
    end

endmodule

// File: vector_wb_regs.sv
`include "vector_defs.svh"

module vector_wb_regs (
    input  logic                               CLK,
    input  logic                               nRST,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [`WB_ADDR_W-1:0]              wb_adr,
    input  logic [`WB_DATA_W-1:0]              wb_dat_w,
    input  logic                               capture,
    input  logic                               busy,
    input  vector_pkg::fp16_t [`VEC_LANES-1:0] res,
    input  logic [`VEC_LANES-1:0]              ovf,
    output logic [`WB_DATA_W-1:0]              wb_dat_r,
    output logic                               wb_ack,
    output logic                               start,
    output vector_pkg::vec_op_t                op,
    output vector_pkg::fp16_t [`VEC_LANES-1:0] a_vec,
    output vector_pkg::fp16_t [`VEC_LANES-1:0] b_vec
);

    logic                               access;
    logic                               wr_en;
    logic                               ctrl_wr;
    logic                               done;
    logic [`VEC_LANES-1:0]              ovf_q;
    vector_pkg::fp16_t [`VEC_LANES-1:0] r_vec;
    logic [`WB_DATA_W-1:0]              rd_data;

    assign access  = wb_cyc && wb_stb && !wb_ack;   // Ack on the next edge
    assign wr_en   = access && wb_we;
    assign ctrl_wr = wr_en && (wb_adr == `REG_CTRL);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            start    <= 1'b0;
            op       <= vector_pkg::VOP_ADD;
            done     <= 1'b0;
            ovf_q    <= '0;
        end else begin
            wb_ack <= access;
            start  <= ctrl_wr && wb_dat_w[0];   // Single-cycle pulse
            if (ctrl_wr) begin
                op <= vector_pkg::vec_op_t'(wb_dat_w[1]);
            end
            // Status clears when a new operation starts
            if (start) begin
                done  <= 1'b0;
                ovf_q <= '0;
            end else if (capture) begin
                done  <= 1'b1;
                ovf_q <= ovf_q | ovf;
            end
            if (access && !wb_we) begin
                wb_dat_r <= rd_data;
            end
        end
    end

    // Operand and result storage
    always_ff @(posedge CLK) begin
        for (int i = 0; i < `VEC_LANES; i++) begin
            if (wr_en && (wb_adr == `WB_ADDR_W'(`REG_A_BASE + 4 * i))) begin
                a_vec[i] <= wb_dat_w[15:0];
            end
            if (wr_en && (wb_adr == `WB_ADDR_W'(`REG_B_BASE + 4 * i))) begin
                b_vec[i] <= wb_dat_w[15:0];
            end
            if (capture) begin
                r_vec[i] <= res[i];
            end
        end
    end

    // Read mux, unmapped reads return 0
    always_comb begin
        rd_data = '0;
        if (wb_adr == `REG_CTRL) begin
            rd_data[1] = op;
        end
        if (wb_adr == `REG_STATUS) begin
            rd_data[0]              = busy;
            rd_data[1]              = done;
            rd_data[8 +: `VEC_LANES] = ovf_q;
        end
        for (int i = 0; i < `VEC_LANES; i++) begin
            if (wb_adr == `WB_ADDR_W'(`REG_A_BASE + 4 * i)) begin
                rd_data[15:0] = a_vec[i];
            end
            if (wb_adr == `WB_ADDR_W'(`REG_B_BASE + 4 * i)) begin
                rd_data[15:0] = b_vec[i];
            end
            if (wb_adr == `WB_ADDR_W'(`REG_R_BASE + 4 * i)) begin
                rd_data[15:0] = r_vec[i];
            end
        end
    end

    a_ack_single: assert property (@(posedge CLK) disable iff (!nRST)
        wb_ack |=> !wb_ack);

endmodule
